// File: design/vdp_port_pkg.sv
// Shared definitions for the V9990-style host port
// Width constants, port and VRAM state enums, bus records
`default_nettype none

package vdp_port_pkg;

    localparam int VRAM_AW = 19;    // VRAM byte address width
    localparam int REG_IW  = 6;     // Register index, R#0 to R#63

    // MODE values seen on the host bus
    typedef enum logic [3:0] {
        P_VRAM     = 4'd0,          // VRAM data
        P_PAL      = 4'd1,          // Palette, reads FF here
        P_CMD      = 4'd2,          // Command data, reads FF here
        P_REG_DATA = 4'd3,          // Register data
        P_REG_SEL  = 4'd4,          // Register select
        P_STATUS   = 4'd5,          // Status, read only
        P_INT      = 4'd6,          // Interrupt flags
        P_SYS      = 4'd7           // System control
    } port_e;

    // P#0 handshake states
    typedef enum logic [2:0] {
        VS_IDLE,
        VS_WR_ACK,                  // WE_n low, waiting for BUSY
        VS_WR_BUSY,                 // Waiting for BUSY to drop
        VS_RD_ACK,                  // OE_n low, waiting for BUSY
        VS_RD_BUSY
    } vram_state_e;

    // One detected CPU access
    typedef struct packed {
        logic       rd;             // One-cycle read pulse
        logic       wr;             // One-cycle write pulse
        port_e      port;
        logic [7:0] data;           // CD_IN captured with the access
    } host_access_t;

    // Read byte handed back to the bus side
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rd_result_t;

    // VRAM request, strobes active low
    typedef struct packed {
        logic               oe_n;
        logic               we_n;
        logic [VRAM_AW-1:0] addr;
        logic [7:0]         din;
    } mem_req_t;

    // Current VRAM pointers from R#0-R#5
    typedef struct packed {
        logic [VRAM_AW-1:0] wr_addr;
        logic               wr_hold;    // R#2 bit 7
        logic [VRAM_AW-1:0] rd_addr;
        logic               rd_hold;    // R#5 bit 7
    } vram_addr_t;

    // Address advance requests
    typedef struct packed {
        logic wr;
        logic rd;
    } vram_step_t;

    // Live status from timing and command blocks
    typedef struct packed {
        logic tr;
        logic vr;
        logic hr;
        logic bd;
        logic eo;
        logic ce;
        logic hi;
        logic vi;
    } status_in_t;

endpackage

`default_nettype wire

// File: design/host_bus.sv
// CPU strobe edge detection and access record
// CD_OUT read-back register and WAIT_n generation
`default_nettype none

module host_bus (
    input  wire                              CLK,
    input  wire                              RESET_n,
    input  wire                              CSR_n,
    input  wire                              CSW_n,
    input  wire [3:0]                        MODE,
    input  wire [7:0]                        CD_IN,
    input  wire vdp_port_pkg::rd_result_t    vram_rd,
    input  wire vdp_port_pkg::rd_result_t    reg_rd,
    input  wire                              vram_busy,
    output vdp_port_pkg::host_access_t       access,
    output logic [7:0]                       CD_OUT,
    output logic                             WAIT_n
);
    import vdp_port_pkg::*;

    logic csr_q;        // Strobe levels at this edge
    logic csw_q;
    logic csr_qq;       // and at the edge before
    logic csw_qq;
    logic rd_fall;
    logic wr_fall;

    // Sample both strobes every edge, idle high
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            csr_q  <= 1'b1;
            csw_q  <= 1'b1;
            csr_qq <= 1'b1;
            csw_qq <= 1'b1;
        end else begin
            csr_q  <= CSR_n;
            csw_q  <= CSW_n;
            csr_qq <= csr_q;
            csw_qq <= csw_q;
        end
    end

    assign rd_fall = csr_qq & ~csr_q;   // High to low between two edges
    assign wr_fall = csw_qq & ~csw_q;

    // Access record, pulses last one cycle
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            access <= '0;
        end else begin
            access.rd   <= rd_fall;
            access.wr   <= wr_fall;
            access.port <= port_e'(MODE);   // 8-15 fall outside the enum, read as FF
            access.data <= CD_IN;
        end
    end

    // Read-back byte, VRAM side first
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            CD_OUT <= 8'hFF;
        end else if (vram_rd.valid) begin
            CD_OUT <= vram_rd.data;
        end else if (reg_rd.valid) begin
            CD_OUT <= reg_rd.data;
        end
    end

    // CPU held off while a VRAM cycle runs
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            WAIT_n <= 1'b1;
        end else begin
            WAIT_n <= ~vram_busy;
        end
    end

endmodule

`default_nettype wire

// File: design/vram_port.sv
// P#0 VRAM access FSM
// Drives the OE_n/WE_n/BUSY memory handshake and returns read bytes
`default_nettype none

module vram_port (
    input  wire                              CLK,
    input  wire                              RESET_n,
    input  wire vdp_port_pkg::host_access_t  access,
    input  wire vdp_port_pkg::vram_addr_t    addr,
    input  wire                              MEM_BUSY,
    input  wire [7:0]                        MEM_DOUT,
    output vdp_port_pkg::mem_req_t           mem,
    output vdp_port_pkg::vram_step_t         step,
    output vdp_port_pkg::rd_result_t         vram_rd,
    output logic                             vram_busy
);
    import vdp_port_pkg::*;

    vram_state_e state;
    logic        vram_acc;      // Access aimed at P#0

    assign vram_acc  = (access.port == P_VRAM);
    assign vram_busy = (state != VS_IDLE);

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state         <= VS_IDLE;
            mem.oe_n      <= 1'b1;
            mem.we_n      <= 1'b1;
            mem.addr      <= '0;
            mem.din       <= '0;
            step          <= '0;
            vram_rd.valid <= 1'b0;
            vram_rd.data  <= '0;
        end else begin
            step          <= '0;      // Pulses by default
            vram_rd.valid <= 1'b0;

            case (state)
                VS_IDLE: begin
                    if (vram_acc && access.wr) begin
                        mem.we_n <= 1'b0;
                        mem.oe_n <= 1'b1;
                        mem.addr <= addr.wr_addr;
                        mem.din  <= access.data;
                        step.wr  <= 1'b1;           // reg_port applies the hold bit
                        state    <= VS_WR_ACK;
                    end else if (vram_acc && access.rd) begin
                        mem.oe_n <= 1'b0;
                        mem.we_n <= 1'b1;
                        mem.addr <= addr.rd_addr;
                        step.rd  <= 1'b1;
                        state    <= VS_RD_ACK;
                    end
                end

                VS_WR_ACK: begin
                    if (MEM_BUSY) begin             // Memory took the write
                        mem.we_n <= 1'b1;
                        state    <= VS_WR_BUSY;
                    end
                end

                VS_WR_BUSY: begin
                    if (!MEM_BUSY) begin
                        state <= VS_IDLE;
                    end
                end

                VS_RD_ACK: begin
                    if (MEM_BUSY) begin
                        mem.oe_n <= 1'b1;
                        state    <= VS_RD_BUSY;
                    end
                end

                VS_RD_BUSY: begin
                    if (!MEM_BUSY) begin            // DOUT is good once BUSY drops
                        vram_rd.valid <= 1'b1;
                        vram_rd.data  <= MEM_DOUT;
                        state         <= VS_IDLE;
                    end
                end

                default: begin
                    mem.oe_n <= 1'b1;
                    mem.we_n <= 1'b1;
                    state    <= VS_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/reg_port.sv
// Register file with P#3/P#4 access and VRAM pointer stepping
// Status read, system control, interrupt flags and INT pins
`default_nettype none

module reg_port (
    input  wire                              CLK,
    input  wire                              RESET_n,
    input  wire vdp_port_pkg::host_access_t  access,
    input  wire vdp_port_pkg::vram_step_t    step,
    input  wire vdp_port_pkg::status_in_t    status,
    output vdp_port_pkg::vram_addr_t         addr,
    output vdp_port_pkg::rd_result_t         reg_rd,
    output logic                             INT0_n,
    output logic                             INT1_n
);
    import vdp_port_pkg::*;

    logic [7:0]         regs [2**REG_IW];   // R#0 to R#63
    logic [7:0]         sel;                // P#4 select value
    logic [REG_IW-1:0]  idx;
    logic               mcs;                // P#7 bit 0
    logic               ce_save;
    logic               hi_save;
    logic               vi_save;
    logic [VRAM_AW-1:0] wr_inc;
    logic [VRAM_AW-1:0] rd_inc;
    logic               reg_wr;
    logic               reg_rd_acc;
    logic [7:0]         rd_byte;

    assign idx        = sel[REG_IW-1:0];
    assign reg_wr     = access.wr && (access.port == P_REG_DATA);
    assign reg_rd_acc = access.rd && (access.port == P_REG_DATA);

    // VRAM pointers, 19 bits over three registers each
    assign addr = '{
        wr_addr: {regs[2][2:0], regs[1], regs[0]},
        wr_hold: regs[2][7],
        rd_addr: {regs[5][2:0], regs[4], regs[3]},
        rd_hold: regs[5][7]
    };

    assign wr_inc = addr.wr_addr + 1'b1;    // Wraps at 2^19
    assign rd_inc = addr.rd_addr + 1'b1;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < 2**REG_IW; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (step.wr && !addr.wr_hold) begin
                regs[0]      <= wr_inc[7:0];
                regs[1]      <= wr_inc[15:8];
                regs[2][2:0] <= wr_inc[VRAM_AW-1:16];   // Upper bits of R#2 kept
            end
            if (step.rd && !addr.rd_hold) begin
                regs[3]      <= rd_inc[7:0];
                regs[4]      <= rd_inc[15:8];
                regs[5][2:0] <= rd_inc[VRAM_AW-1:16];
            end
            if (reg_wr) begin
                regs[idx] <= access.data;               // P#3 write
            end
        end
    end

    // Select register and index auto-increment
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sel <= '0;
        end else if (access.wr && (access.port == P_REG_SEL)) begin
            sel <= access.data;
        end else if (reg_wr && !sel[7]) begin           // Write inhibit
            sel[REG_IW-1:0] <= idx + 1'b1;
        end else if (reg_rd_acc && !sel[6]) begin       // Read inhibit
            sel[REG_IW-1:0] <= idx + 1'b1;
        end
    end

    // System control
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            mcs <= 1'b0;
        end else if (access.wr && (access.port == P_SYS)) begin
            mcs <= access.data[0];
        end
    end

    // Saved interrupt flags, P#6 write is one-to-clear
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            ce_save <= 1'b0;
            hi_save <= 1'b0;
            vi_save <= 1'b0;
        end else if (access.wr && (access.port == P_INT)) begin
            ce_save <= ce_save & ~access.data[2];
            hi_save <= hi_save & ~access.data[1];
            vi_save <= vi_save & ~access.data[0];
        end else begin
            ce_save <= ce_save | status.ce;
            hi_save <= hi_save | status.hi;
            vi_save <= vi_save | status.vi;
        end
    end

    // R#9 enables, bit 2 CE, bit 1 HI, bit 0 VI
    assign INT0_n = ~((ce_save & regs[9][2]) | (vi_save & regs[9][0]));
    assign INT1_n = ~(hi_save & regs[9][1]);

    // Read mux by port
    always_comb begin
        case (access.port)
            P_REG_DATA: rd_byte = regs[idx];
            P_STATUS:   rd_byte = {status.tr, status.vr, status.hr, status.bd,
                                   1'b0, mcs, status.eo, status.ce};
            P_INT:      rd_byte = {5'b00000, ce_save | status.ce,
                                   hi_save | status.hi, vi_save | status.vi};
            default:    rd_byte = 8'hFF;                // Ports not kept, write-only ports
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            reg_rd <= '0;
        end else begin
            reg_rd.valid <= access.rd && (access.port != P_VRAM);
            reg_rd.data  <= rd_byte;
        end
    end

endmodule

`default_nettype wire

// File: design/vdp_port_top.sv
// Host port top level
// host_bus in front of vram_port and reg_port
`default_nettype none

module vdp_port_top (
    input  wire                              CLK,
    input  wire                              RESET_n,
    input  wire                              CSR_n,
    input  wire                              CSW_n,
    input  wire [3:0]                        MODE,
    input  wire [7:0]                        CD_IN,
    input  wire vdp_port_pkg::status_in_t    status,
    input  wire                              MEM_BUSY,
    input  wire [7:0]                        MEM_DOUT,
    output logic [7:0]                       CD_OUT,
    output logic                             WAIT_n,
    output logic                             INT0_n,
    output logic                             INT1_n,
    output vdp_port_pkg::mem_req_t           mem
);
    import vdp_port_pkg::*;

    host_access_t access;       // Detected CPU access
    rd_result_t   vram_rd;      // P#0 read byte
    rd_result_t   reg_rd;       // All other read bytes
    vram_addr_t   addr;         // Pointers from R#0-R#5
    vram_step_t   step;
    logic         vram_busy;

    host_bus host_bus_u (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .CSR_n     (CSR_n),
        .CSW_n     (CSW_n),
        .MODE      (MODE),
        .CD_IN     (CD_IN),
        .vram_rd   (vram_rd),
        .reg_rd    (reg_rd),
        .vram_busy (vram_busy),
        .access    (access),
        .CD_OUT    (CD_OUT),
        .WAIT_n    (WAIT_n)
    );

    vram_port vram_port_u (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .access    (access),
        .addr      (addr),
        .MEM_BUSY  (MEM_BUSY),
        .MEM_DOUT  (MEM_DOUT),
        .mem       (mem),
        .step      (step),
        .vram_rd   (vram_rd),
        .vram_busy (vram_busy)
    );

    reg_port reg_port_u (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .access  (access),
        .step    (step),
        .status  (status),
        .addr    (addr),
        .reg_rd  (reg_rd),
        .INT0_n  (INT0_n),
        .INT1_n  (INT1_n)
    );

endmodule

`default_nettype wire

// File: testbench/vdp_port_chk.sv
// Concurrent assertions on the VRAM memory handshake
// Bound into vram_port
`default_nettype none

module vdp_port_chk (
    input wire                              CLK,
    input wire                              RESET_n,
    input wire vdp_port_pkg::mem_req_t      mem,
    input wire                              MEM_BUSY,
    input wire vdp_port_pkg::rd_result_t    vram_rd,
    input wire vdp_port_pkg::vram_state_e   state
);
    import vdp_port_pkg::*;

    // Only one strobe at a time
    one_strobe: assert property (@(posedge CLK) disable iff (!RESET_n)
        !(!mem.oe_n && !mem.we_n))
        else $error("OE_n and WE_n low together");

    we_held: assert property (@(posedge CLK) disable iff (!RESET_n)
        (!mem.we_n && !MEM_BUSY) |=> !mem.we_n)     // Low until BUSY seen
        else $error("WE_n released before BUSY was seen");

    oe_held: assert property (@(posedge CLK) disable iff (!RESET_n)
        (!mem.oe_n && !MEM_BUSY) |=> !mem.oe_n)
        else $error("OE_n released before BUSY was seen");

    // Read byte only as the FSM drops back to idle
    rd_on_idle: assert property (@(posedge CLK) disable iff (!RESET_n)
        vram_rd.valid |-> (state == VS_IDLE) && ($past(state) == VS_RD_BUSY))
        else $error("Read byte returned outside the entry to idle");

endmodule

bind vram_port vdp_port_chk vram_chk_u (
    .CLK      (CLK),
    .RESET_n  (RESET_n),
    .mem      (mem),
    .MEM_BUSY (MEM_BUSY),
    .vram_rd  (vram_rd),
    .state    (state)
);

`default_nettype wire

// File: testbench/tb_vdp_port.sv
// Testbench for the host port top level
// Clock, reset, VRAM memory model, directed tests and compare tasks
`default_nettype none

module tb_vdp_port;
    import vdp_port_pkg::*;

    localparam int WAIT_LIMIT = 64;     // Cycles allowed per wait loop

    logic        CLK      = 1'b0;
    logic        RESET_n  = 1'b0;
    logic        CSR_n    = 1'b1;
    logic        CSW_n    = 1'b1;
    logic [3:0]  MODE     = 4'd0;
    logic [7:0]  CD_IN    = 8'h00;
    status_in_t  status   = '0;
    logic        MEM_BUSY = 1'b0;
    logic [7:0]  MEM_DOUT = 8'h00;
    logic [7:0]  CD_OUT;
    logic        WAIT_n;
    logic        INT0_n;
    logic        INT1_n;
    mem_req_t    mem;

    logic [7:0]  vram_model [512];      // Indexed by addr[8:0]
    mem_req_t    req_log [$];           // Request as seen when BUSY rises
    logic [31:0] lcg_state = 32'd32;
    int          busy_delay = 0;
    int          busy_hold  = 0;
    logic        req_seen   = 1'b0;

    vdp_port_top vdp_port_top_i (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .CSR_n    (CSR_n),
        .CSW_n    (CSW_n),
        .MODE     (MODE),
        .CD_IN    (CD_IN),
        .status   (status),
        .MEM_BUSY (MEM_BUSY),
        .MEM_DOUT (MEM_DOUT),
        .CD_OUT   (CD_OUT),
        .WAIT_n   (WAIT_n),
        .INT0_n   (INT0_n),
        .INT1_n   (INT1_n),
        .mem      (mem)
    );

    always #50 CLK = ~CLK;

    function automatic logic [14:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:16];
    endfunction

    // Power-up contents, every address bit matters
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 5 + (a >> 8) * 59 + 17);
    endfunction

    function automatic mem_req_t make_req(input logic oe_n, input logic we_n,
                                          input logic [VRAM_AW-1:0] a, input logic [7:0] d);
        mem_req_t r;
        r.oe_n = oe_n;
        r.we_n = we_n;
        r.addr = a;
        r.din  = d;
        return r;
    endfunction

    // Memory model, BUSY 1 to 4 cycles after a strobe, held for 2
    always @(negedge CLK) begin
        if (!RESET_n) begin
            for (int i = 0; i < 512; i++) begin
                vram_model[i] = fill_byte(i);
            end
            MEM_BUSY  = 1'b0;
            req_seen  = 1'b0;
            busy_hold = 0;
        end else if (busy_hold != 0) begin
            busy_hold--;
            if (busy_hold == 0) MEM_BUSY = 1'b0;
        end else if (req_seen) begin
            busy_delay--;
            if (busy_delay == 0) begin
                MEM_BUSY  = 1'b1;
                busy_hold = 2;
                req_seen  = 1'b0;
                req_log.push_back(mem);
                if (!mem.we_n) vram_model[mem.addr[8:0]] = mem.din;
                else MEM_DOUT = vram_model[mem.addr[8:0]];  // Stable until BUSY drops
            end
        end else if (!mem.oe_n || !mem.we_n) begin
            req_seen   = 1'b1;
            busy_delay = int'(next_rand() % 15'd4) + 1;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic expect_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic expect_pin(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic expect_mem(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) fail_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic expect_ints(input logic int0, input logic int1);
        if ({INT0_n, INT1_n} !== {int0, int1}) begin
            fail_run($sformatf("[FAIL] INT0_n,INT1_n got %h expected %h",
                               {INT0_n, INT1_n}, {int0, int1}));
        end
    endtask

    task automatic wait_for_wait_n(input logic level);
        int cycles;
        cycles = 0;
        while (WAIT_n !== level && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (WAIT_n !== level) fail_run($sformatf("Timeout: WAIT_n never went %0b", level));
    endtask

    // CPU write, returns once the effect is visible (E+2)
    task automatic write_port(input port_e port, input logic [7:0] data);
        MODE  = port;
        CD_IN = data;
        CSW_n = 1'b0;
        @(negedge CLK);
        CSW_n = 1'b1;
        repeat (2) @(negedge CLK);
    endtask

    // CPU read of a non-VRAM port, byte on CD_OUT from E+3
    task automatic read_port(input port_e port, output logic [7:0] data);
        MODE  = port;
        CSR_n = 1'b0;
        @(negedge CLK);
        CSR_n = 1'b1;
        repeat (3) @(negedge CLK);
        data = CD_OUT;
    endtask

    task automatic write_vram(input logic [7:0] data);
        MODE  = P_VRAM;
        CD_IN = data;
        CSW_n = 1'b0;
        @(negedge CLK);
        CSW_n = 1'b1;
        wait_for_wait_n(1'b0);
        wait_for_wait_n(1'b1);
    endtask

    task automatic read_vram(output logic [7:0] data);
        MODE  = P_VRAM;
        CSR_n = 1'b0;
        @(negedge CLK);
        CSR_n = 1'b1;
        wait_for_wait_n(1'b0);
        wait_for_wait_n(1'b1);
        data = CD_OUT;                      // Valid with the WAIT_n rise
    endtask

    task automatic set_regs(input logic [7:0] first, input logic [7:0] b0,
                            input logic [7:0] b1, input logic [7:0] b2);
        write_port(P_REG_SEL, first);
        write_port(P_REG_DATA, b0);         // Index steps after each write
        write_port(P_REG_DATA, b1);
        write_port(P_REG_DATA, b2);
    endtask

    task automatic pulse_flags(input logic [2:0] f);    // ce hi vi
        status.ce = f[2];
        status.hi = f[1];
        status.vi = f[0];
        @(negedge CLK);
        status = '0;
    endtask

    // Reads R#0-R#5 in a row and compares them
    task automatic expect_pointers(input logic [7:0] exp [6]);
        logic [7:0] b;
        write_port(P_REG_SEL, 8'd0);
        for (int k = 0; k < 6; k++) begin
            read_port(P_REG_DATA, b);
            expect_byte($sformatf("R#%0d", k), b, exp[k]);
        end
    endtask

    task automatic reset_values();
        expect_byte("CD_OUT", CD_OUT, 8'hFF);
        expect_pin("WAIT_n", WAIT_n, 1'b1);
        expect_ints(1'b1, 1'b1);
        expect_pin("MEM_OE_n", mem.oe_n, 1'b1);
        expect_pin("MEM_WE_n", mem.we_n, 1'b1);
    endtask

    task automatic register_access();
        logic [7:0] b;
        set_regs(8'd10, 8'hA1, 8'hB2, 8'hC3);
        write_port(P_REG_SEL, 8'd10);
        read_port(P_REG_DATA, b);
        expect_byte("R#10", b, 8'hA1);
        read_port(P_REG_DATA, b);
        expect_byte("R#11", b, 8'hB2);
        read_port(P_REG_DATA, b);
        expect_byte("R#12", b, 8'hC3);
        set_regs(8'h80 | 8'd20, 8'h11, 8'h22, 8'h33);     // Write hold, all into R#20
        write_port(P_REG_SEL, 8'd20);
        read_port(P_REG_DATA, b);
        expect_byte("R#20", b, 8'h33);
        read_port(P_REG_DATA, b);
        expect_byte("R#21", b, 8'h00);
        write_port(P_REG_SEL, 8'h40 | 8'd10);               // Read hold
        repeat (3) begin
            read_port(P_REG_DATA, b);
            expect_byte("R#10 held", b, 8'hA1);
        end
        read_port(P_PAL, b);
        expect_byte("P#1", b, 8'hFF);
    endtask

    task automatic vram_write_read();
        logic [7:0] data [4];
        logic [7:0] b;
        mem_req_t   r;
        int         base;
        data = '{8'h5A, 8'hA5, 8'h3C, 8'hC3};
        set_regs(8'd0, 8'h00, 8'h01, 8'h00);                // Write pointer 00100
        base = req_log.size();
        for (int k = 0; k < 4; k++) write_vram(data[k]);
        for (int k = 0; k < 4; k++) begin
            expect_mem($sformatf("write request %0d", k), req_log[base + k],
                       make_req(1'b1, 1'b0, 19'(32'h100 + k), data[k]));
        end
        set_regs(8'd3, 8'h00, 8'h01, 8'h00);                // Read pointer 00100
        base = req_log.size();
        for (int k = 0; k < 4; k++) begin
            read_vram(b);
            expect_byte($sformatf("P#0 read %0d", k), b, data[k]);
            r = req_log[base + k];
            r.din = '0;                                      // Unused on reads
            expect_mem("read request", r, make_req(1'b0, 1'b1, 19'(32'h100 + k), 8'h00));
        end
        expect_pointers('{8'h04, 8'h01, 8'h00, 8'h04, 8'h01, 8'h00});
    endtask

    task automatic address_hold();
        logic [7:0] b;
        mem_req_t   r;
        int         base;
        set_regs(8'd0, 8'h40, 8'h00, 8'h80);                // 00040 with hold
        base = req_log.size();
        write_vram(8'h77);
        write_vram(8'h88);
        expect_mem("held write 0", req_log[base], make_req(1'b1, 1'b0, 19'h00040, 8'h77));
        expect_mem("held write 1", req_log[base + 1], make_req(1'b1, 1'b0, 19'h00040, 8'h88));
        expect_byte("model 040", vram_model[9'h040], 8'h88);
        set_regs(8'd3, 8'h50, 8'h00, 8'h80);
        base = req_log.size();
        for (int k = 0; k < 2; k++) begin
            read_vram(b);
            expect_byte("held read", b, fill_byte(32'h050));
            r = req_log[base + k];
            r.din = '0;
            expect_mem("held read request", r, make_req(1'b0, 1'b1, 19'h00050, 8'h00));
        end
        expect_pointers('{8'h40, 8'h00, 8'h80, 8'h50, 8'h00, 8'h80});
    endtask

    task automatic interrupts();
        logic [7:0] b;
        write_port(P_REG_SEL, 8'd9);
        write_port(P_REG_DATA, 8'h00);                      // Enables off
        pulse_flags(3'b100);
        pulse_flags(3'b010);
        pulse_flags(3'b001);
        expect_ints(1'b1, 1'b1);
        read_port(P_INT, b);
        expect_byte("P#6 saved", b, 8'h07);
        write_port(P_INT, 8'h07);
        read_port(P_INT, b);
        expect_byte("P#6 cleared", b, 8'h00);
        write_port(P_REG_SEL, 8'd9);
        write_port(P_REG_DATA, 8'h07);                      // CE, HI, VI enabled
        expect_ints(1'b1, 1'b1);
        pulse_flags(3'b100);
        expect_ints(1'b0, 1'b1);
        read_port(P_INT, b);
        expect_byte("P#6 ce", b, 8'h04);
        write_port(P_INT, 8'h04);
        expect_ints(1'b1, 1'b1);
        pulse_flags(3'b010);
        expect_ints(1'b1, 1'b0);
        read_port(P_INT, b);
        expect_byte("P#6 hi", b, 8'h02);
        write_port(P_INT, 8'h02);
        pulse_flags(3'b001);
        expect_ints(1'b0, 1'b1);
        pulse_flags(3'b110);
        expect_ints(1'b0, 1'b0);
        read_port(P_INT, b);
        expect_byte("P#6 all", b, 8'h07);
        write_port(P_INT, 8'h07);
        expect_ints(1'b1, 1'b1);
        read_port(P_INT, b);
        expect_byte("P#6 after clear", b, 8'h00);
    endtask

    // P#5 layout tr vr hr bd 0 mcs eo ce
    task automatic status_control();
        logic [7:0] b;
        status_in_t s;
        write_port(P_SYS, 8'h01);                           // MCS on
        s = '0;
        s.tr = 1'b1;
        s.hr = 1'b1;
        s.eo = 1'b1;
        status = s;
        read_port(P_STATUS, b);
        expect_byte("P#5 MCS set", b, 8'hA6);
        write_port(P_SYS, 8'h00);
        s = '0;
        s.vr = 1'b1;
        s.bd = 1'b1;
        s.ce = 1'b1;
        status = s;
        read_port(P_STATUS, b);
        expect_byte("P#5 MCS clear", b, 8'h51);
        status = '0;
    endtask

    initial begin
        repeat (3) @(negedge CLK);                          // Three reset cycles
        RESET_n = 1'b1;
        @(negedge CLK);
        reset_values();
        register_access();
        vram_write_read();
        address_hold();
        interrupts();
        status_control();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
design/vdp_port_pkg.sv
design/host_bus.sv
design/vram_port.sv
design/reg_port.sv
design/vdp_port_top.sv
testbench/vdp_port_chk.sv
testbench/tb_vdp_port.sv

// File: run.sh
#!/bin/sh
# Build and run the host port testbench with Verilator
rm -f sim.log
verilator --binary --assert -Wno-fatal -f all.f --top-module tb_vdp_port -o tb_vdp_port \
    && ./obj_dir/tb_vdp_port > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || exit 1
